/* src/mm_cfg.svh */
// Matrix engine build constants
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// Element format
`define MM_WIDTH      16   // Q8.8 element, one word
`define MM_FRAC_WIDTH 8    // Fraction bits

// Job shape
`define MM_K          4    // Inner dimension
`define MM_I_ROWS     4    // Input rows per job
`define MM_W_ROWS     2    // Weight rows per job, at most MM_I_ROWS

// Buffering
`define MM_IN_DEPTH   8    // Two jobs of input rows
`define MM_OUT_DEPTH  4    // Output slots, also the credit pool

`endif

/* src/mm_pkg.sv */
// Matrix engine data types
`default_nettype none

`include "mm_cfg.svh"

package mm_pkg;

    typedef logic signed [`MM_WIDTH-1:0] elem_t;       // Signed Q8.8

    typedef elem_t [`MM_K-1:0] k_row_t;                // Ingest payload
    typedef elem_t [`MM_W_ROWS-1:0] c_row_t;           // One row of C

    typedef struct packed
    {
        logic   last;                                  // Last row of a job
        c_row_t data;
    } out_beat_t;                                      // Output FIFO payload

    typedef k_row_t [`MM_I_ROWS-1:0] i_mat_t;          // Input operand
    typedef k_row_t [`MM_W_ROWS-1:0] w_mat_t;          // Weight operand

    // Full product plus growth for the K-term sum
    typedef logic signed [2*`MM_WIDTH+1:0] acc_t;

endpackage

`default_nettype wire

/* src/mm_if.sv */
// Internal links of the matrix engine
`default_nettype none

// Loader to compute job handoff
interface mm_job_if;

    logic           start;   // Single-cycle handoff pulse
    logic           busy;    // Compute owns a job
    mm_pkg::i_mat_t i_mat;   // Input rows of the job
    mm_pkg::w_mat_t w_mat;   // Weight rows of the job

    modport source (output start, output i_mat, output w_mat, input busy);
    modport sink (input start, input i_mat, input w_mat, output busy);

endinterface

// Compute to output FIFO link
interface mm_credit_if;

    logic              valid;          // Beat pushed this cycle
    mm_pkg::out_beat_t beat;           // Row of C with last flag
    logic              credit_return;  // One slot freed downstream
    logic              count_ok;       // No push into a full output FIFO

    modport source (output valid, output beat, input credit_return);
    modport sink (
        input  valid,
        input  beat,
        output credit_return,
        output count_ok
    );

endinterface

`default_nettype wire

/* src/mm_stream_fifo.sv */
// Synchronous stream FIFO
`default_nettype none

module mm_stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input  wire                        aclk,
    input  wire                        aresetn,
    input  wire                        wr_en_i,
    input  wire payload_t              wr_data_i,
    output logic                       full_o,
    input  wire                        rd_en_i,
    output payload_t                   rd_data_o,
    output logic                       empty_o,
    output logic [$clog2(DEPTH+1)-1:0] count_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;   // Pointer width
    localparam int CW = $clog2(DEPTH + 1);                  // Occupancy width

    payload_t      mem [DEPTH];   // Storage, no reset
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          do_wr;
    logic          do_rd;

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_wr     = wr_en_i && !full_o;       // Drop writes when full
    assign do_rd     = rd_en_i && !empty_o;      // Ignore reads when empty
    assign full_o    = (count_q == CW'(DEPTH));
    assign empty_o   = (count_q == '0);
    assign count_o   = count_q;
    assign rd_data_o = mem[rd_ptr_q];            // Head visible the cycle after write

    always_ff @(posedge aclk)
    begin
        if (do_wr)
            mem[wr_ptr_q] <= wr_data_i;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr_q <= next_ptr(wr_ptr_q);
            if (do_rd)
                rd_ptr_q <= next_ptr(rd_ptr_q);
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;   // Push only
                2'b01:   count_q <= count_q - 1'b1;   // Pop only
                default: count_q <= count_q;          // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/mm_loader.sv */
// Job assembly stage
`default_nettype none

`include "mm_cfg.svh"

module mm_loader (
    input  wire                                 aclk,
    input  wire                                 aresetn,
    input  wire mm_pkg::k_row_t                 i_rd_data_i,
    input  wire [$clog2(`MM_IN_DEPTH+1)-1:0]    i_count_i,
    output logic                                i_rd_en_o,
    input  wire mm_pkg::k_row_t                 w_rd_data_i,
    input  wire [$clog2(`MM_IN_DEPTH+1)-1:0]    w_count_i,
    output logic                                w_rd_en_o,
    mm_job_if.source                            job
);

    localparam int RW = (`MM_I_ROWS > 1) ? $clog2(`MM_I_ROWS) : 1;   // Row counter width

    typedef enum logic [1:0]
    {
        ST_WAIT,   // Not enough rows queued yet
        ST_FILL,   // Popping rows into the buffers
        ST_HOLD    // Full job waiting for compute
    } state_t;

    state_t        state_q;
    logic [RW-1:0] row_q;       // Buffer slot of the current pop
    logic          have_job;

    assign have_job  = (i_count_i >= `MM_I_ROWS) && (w_count_i >= `MM_W_ROWS);
    assign i_rd_en_o = (state_q == ST_FILL);                        // One row per cycle
    assign w_rd_en_o = (state_q == ST_FILL) && (row_q < `MM_W_ROWS);  // Stops after W_ROWS
    assign job.start = (state_q == ST_HOLD) && !job.busy;           // Single pulse, leaves HOLD

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state_q <= ST_WAIT;
            row_q   <= '0;
        end
        else
        begin
            case (state_q)
                ST_WAIT:
                begin
                    row_q <= '0;
                    if (have_job)
                        state_q <= ST_FILL;
                end
                ST_FILL:
                begin
                    if (row_q == RW'(`MM_I_ROWS - 1))
                        state_q <= ST_HOLD;   // Last input row popped
                    else
                        row_q <= row_q + 1'b1;
                end
                ST_HOLD:
                begin
                    if (job.start)
                        state_q <= ST_WAIT;   // Compute has its copy, refill
                end
                default: state_q <= ST_WAIT;
            endcase
        end
    end

    // Operand buffers, read by compute on start
    always_ff @(posedge aclk)
    begin
        if (i_rd_en_o)
            job.i_mat[row_q] <= i_rd_data_i;
        if (w_rd_en_o)
            job.w_mat[row_q] <= w_rd_data_i;
    end

endmodule

`default_nettype wire

/* src/mm_compute.sv */
// Multiply-accumulate stage with credit output
`default_nettype none

`include "mm_cfg.svh"

module mm_compute (
    input  wire         aclk,
    input  wire         aresetn,
    mm_job_if.sink      job,
    mm_credit_if.source out
);

    localparam int RW  = (`MM_I_ROWS > 1) ? $clog2(`MM_I_ROWS) : 1;   // Row counter width
    localparam int KW  = (`MM_K > 1) ? $clog2(`MM_K) : 1;             // K counter width
    localparam int CRW = $clog2(`MM_OUT_DEPTH + 1) + 1;               // Credits plus sign bit

    mm_pkg::i_mat_t        i_q;                    // Latched input rows
    mm_pkg::w_mat_t        w_q;                    // Latched weight rows
    mm_pkg::acc_t          acc_q [`MM_W_ROWS];     // One per column of C
    logic                  busy_q;
    logic                  emit_q;                 // Row done, waiting to send
    logic [RW-1:0]         row_q;
    logic [KW-1:0]         k_q;
    logic signed [CRW-1:0] credit_q;               // Free output FIFO slots
    logic                  mac_en;
    logic                  last_row;

    assign mac_en    = busy_q && !emit_q;
    assign last_row  = (row_q == RW'(`MM_I_ROWS - 1));
    assign job.busy  = busy_q;
    assign out.valid = emit_q && (credit_q > 0);   // Never send without a credit

    always_ff @(posedge aclk)
    begin
        if (job.start)
        begin
            i_q <= job.i_mat;
            w_q <= job.w_mat;
        end
    end

    // All columns step through k together, first term overwrites
    always_ff @(posedge aclk)
    begin
        if (mac_en)
        begin
            for (int c = 0; c < `MM_W_ROWS; c++)
            begin
                acc_q[c] <= ((k_q == '0) ? mm_pkg::acc_t'(0) : acc_q[c])
                          + $signed(i_q[row_q][k_q]) * $signed(w_q[c][k_q]);
            end
        end
    end

    // Q8.8 rescale, arithmetic shift then keep the low word
    always_comb
    begin
        mm_pkg::acc_t shifted;
        out.beat.last = last_row;                  // Tags row I_ROWS-1
        for (int c = 0; c < `MM_W_ROWS; c++)
        begin
            shifted          = acc_q[c] >>> `MM_FRAC_WIDTH;
            out.beat.data[c] = shifted[`MM_WIDTH-1:0];
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            busy_q   <= 1'b0;
            emit_q   <= 1'b0;
            row_q    <= '0;
            k_q      <= '0;
            credit_q <= CRW'(`MM_OUT_DEPTH);       // Output FIFO starts empty
        end
        else
        begin
            if (job.start)
            begin
                busy_q <= 1'b1;
                row_q  <= '0;
                k_q    <= '0;
            end
            else if (mac_en)
            begin
                if (k_q == KW'(`MM_K - 1))
                begin
                    k_q    <= '0;
                    emit_q <= 1'b1;                // Sum complete
                end
                else
                    k_q <= k_q + 1'b1;
            end
            else if (out.valid)
            begin
                emit_q <= 1'b0;
                if (last_row)
                    busy_q <= 1'b0;                // Job finished
                else
                    row_q <= row_q + 1'b1;
            end
            case ({out.valid, out.credit_return})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;     // Spend and return cancel
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/mm_axis_top.sv */
// AXI-Stream matrix multiply top level
`default_nettype none

`include "mm_cfg.svh"

module mm_axis_top (
    input  wire                             aclk,
    input  wire                             aresetn,
    input  wire [`MM_K*`MM_WIDTH-1:0]       s_axis_i_tdata_i,
    input  wire                             s_axis_i_tvalid_i,
    output logic                            s_axis_i_tready_o,
    input  wire [`MM_K*`MM_WIDTH-1:0]       s_axis_w_tdata_i,
    input  wire                             s_axis_w_tvalid_i,
    output logic                            s_axis_w_tready_o,
    output logic [`MM_W_ROWS*`MM_WIDTH-1:0] m_axis_tdata_o,
    output logic                            m_axis_tvalid_o,
    output logic                            m_axis_tlast_o,
    input  wire                             m_axis_tready_i
);

    localparam int IN_CW  = $clog2(`MM_IN_DEPTH + 1);

    mm_pkg::k_row_t    i_rd_data;
    mm_pkg::k_row_t    w_rd_data;
    logic [IN_CW-1:0]  i_count;
    logic [IN_CW-1:0]  w_count;
    logic              i_full;
    logic              w_full;
    logic              i_rd_en;
    logic              w_rd_en;
    mm_pkg::out_beat_t o_rd_data;
    logic              o_full;
    logic              o_empty;
    logic              o_pop;               // Output beat accepted downstream

    mm_job_if    job_if ();
    mm_credit_if credit_if ();

    assign s_axis_i_tready_o       = !i_full;
    assign s_axis_w_tready_o       = !w_full;
    assign m_axis_tvalid_o         = !o_empty;
    assign m_axis_tdata_o          = o_rd_data.data;
    assign m_axis_tlast_o          = o_rd_data.last;
    assign o_pop                   = m_axis_tvalid_o && m_axis_tready_i;
    assign credit_if.credit_return = o_pop;   // Freed slot goes back to compute
    assign credit_if.count_ok      = !(o_full && credit_if.valid);

    mm_stream_fifo #(.payload_t(mm_pkg::k_row_t), .DEPTH(`MM_IN_DEPTH)) fifo_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .wr_en_i   (s_axis_i_tvalid_i),
        .wr_data_i (s_axis_i_tdata_i),
        .full_o    (i_full),
        .rd_en_i   (i_rd_en),
        .rd_data_o (i_rd_data),
        .empty_o   (),
        .count_o   (i_count)
    );

    mm_stream_fifo #(.payload_t(mm_pkg::k_row_t), .DEPTH(`MM_IN_DEPTH)) fifo_w (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .wr_en_i   (s_axis_w_tvalid_i),
        .wr_data_i (s_axis_w_tdata_i),
        .full_o    (w_full),
        .rd_en_i   (w_rd_en),
        .rd_data_o (w_rd_data),
        .empty_o   (),
        .count_o   (w_count)
    );

    mm_loader u_loader (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_rd_data_i (i_rd_data),
        .i_count_i   (i_count),
        .i_rd_en_o   (i_rd_en),
        .w_rd_data_i (w_rd_data),
        .w_count_i   (w_count),
        .w_rd_en_o   (w_rd_en),
        .job         (job_if)
    );

    mm_compute u_compute (
        .aclk    (aclk),
        .aresetn (aresetn),
        .job     (job_if),
        .out     (credit_if)
    );

    // Credits guarantee room so compute needs no ready
    mm_stream_fifo #(.payload_t(mm_pkg::out_beat_t), .DEPTH(`MM_OUT_DEPTH)) fifo_o (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .wr_en_i   (credit_if.valid),
        .wr_data_i (credit_if.beat),
        .full_o    (o_full),
        .rd_en_i   (o_pop),
        .rd_data_o (o_rd_data),
        .empty_o   (o_empty),
        .count_o   ()
    );

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
// Testbench clock and reset
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD       = 100,   // ns
    parameter int RESET_CYCLES = 2
) (
    output logic aclk_o,
    output logic aresetn_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        aclk_o = 1'b0;
        forever #(PERIOD / 2) aclk_o = ~aclk_o;
    end

    initial
    begin
        aresetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk_o);   // Reset seen on two rising edges
        @(negedge aclk_o);
        aresetn_o = 1'b1;                          // Release away from the sampling edge
    end

endmodule

`default_nettype wire

/* sim/mm_axis_chk.sv */
// Output stream and credit assertions
`default_nettype none

`include "mm_cfg.svh"

module mm_axis_chk (
    input wire                                   aclk,
    input wire                                   aresetn,
    input wire [`MM_W_ROWS*`MM_WIDTH-1:0]        tdata_i,
    input wire                                   tvalid_i,
    input wire                                   tready_i,
    input wire signed [$clog2(`MM_OUT_DEPTH+1):0] credit_i,
    input wire                                   count_ok_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // Read by the testbench summary

    hold_data: assert property (@(posedge aclk) disable iff (!aresetn)
        tvalid_i && !tready_i |=> $stable(tdata_i))
        else
        begin
            fail_count++;
            $error("Output data changed while the beat was stalled");
        end

    // Reset must leave the output stream idle
    quiet_reset: assert property (@(posedge aclk) !aresetn |=> !tvalid_i)
        else
        begin
            fail_count++;
            $error("Output valid seen while in reset");
        end

    credit_range: assert property (@(posedge aclk) disable iff (!aresetn)
        credit_i >= 0 && credit_i <= `MM_OUT_DEPTH)
        else
        begin
            fail_count++;
            $error("Credit count left its legal range");
        end

    no_overflow: assert property (@(posedge aclk) disable iff (!aresetn) count_ok_i)
        else
        begin
            fail_count++;
            $error("Output FIFO written while full");
        end

endmodule

bind mm_axis_top mm_axis_chk chk (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .tdata_i    (m_axis_tdata_o),
    .tvalid_i   (m_axis_tvalid_o),
    .tready_i   (m_axis_tready_i),
    .credit_i   (u_compute.credit_q),
    .count_ok_i (credit_if.count_ok)
);

`default_nettype wire

/* sim/mm_axis_tb.sv */
// Matrix engine testbench
`default_nettype none

`include "mm_cfg.svh"

module mm_axis_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS       = 5;
    localparam int PERIOD          = 100;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (`MM_I_ROWS * `MM_K + 40);

    logic                            aclk;
    logic                            aresetn;
    mm_pkg::k_row_t                  i_tdata;
    logic                            i_tvalid;
    logic                            i_tready;
    mm_pkg::k_row_t                  w_tdata;
    logic                            w_tvalid;
    logic                            w_tready;
    logic [`MM_W_ROWS*`MM_WIDTH-1:0] o_tdata;
    logic                            o_tvalid;
    logic                            o_tlast;
    logic                            o_tready;

    string             test_name [NUM_TESTS];
    mm_pkg::i_mat_t    i_tab [NUM_TESTS];
    mm_pkg::w_mat_t    w_tab [NUM_TESTS];
    bit                stall_tab [NUM_TESTS];   // Random ready on this test's beats
    mm_pkg::k_row_t    i_rows [$];              // Flattened input stream
    mm_pkg::k_row_t    w_rows [$];
    mm_pkg::out_beat_t exp_q [$];               // Expected beats in order
    int                exp_test [$];            // Owning test of each beat
    int                errors  = 0;
    int                checked = 0;

    tb_clk_gen #(.PERIOD(PERIOD)) clk_gen (.aclk_o(aclk), .aresetn_o(aresetn));

    mm_axis_top dut (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .s_axis_i_tdata_i  (i_tdata),
        .s_axis_i_tvalid_i (i_tvalid),
        .s_axis_i_tready_o (i_tready),
        .s_axis_w_tdata_i  (w_tdata),
        .s_axis_w_tvalid_i (w_tvalid),
        .s_axis_w_tready_o (w_tready),
        .m_axis_tdata_o    (o_tdata),
        .m_axis_tvalid_o   (o_tvalid),
        .m_axis_tlast_o    (o_tlast),
        .m_axis_tready_i   (o_tready)
    );

    // Sum of I[r][k]*W[c][k], arithmetic shift by the fraction, low 16 bits
    function automatic mm_pkg::c_row_t ref_row(input mm_pkg::i_mat_t a,
                                               input mm_pkg::w_mat_t b, input int r);
        mm_pkg::c_row_t res;
        longint         sum;
        for (int c = 0; c < `MM_W_ROWS; c++)
        begin
            sum = 0;
            for (int k = 0; k < `MM_K; k++)
                sum += longint'(a[r][k]) * longint'(b[c][k]);
            res[c] = mm_pkg::elem_t'(sum >>> `MM_FRAC_WIDTH);
        end
        return res;
    endfunction

    task automatic build_table();
        mm_pkg::out_beat_t beat;
        test_name = '{"small_pos", "neg_large", "b2b_job_a", "b2b_job_b", "ready_stall"};
        stall_tab = '{0, 0, 0, 0, 1};
        for (int r = 0; r < `MM_I_ROWS; r++)
            for (int k = 0; k < `MM_K; k++)
            begin
                i_tab[0][r][k] = mm_pkg::elem_t'((r + k + 1) * 256);   // Whole numbers 1..7
                i_tab[1][r][k] = ((r + k) % 2) ? mm_pkg::elem_t'(16'h8000 + r)
                                               : mm_pkg::elem_t'(16'h7FFF - k * 4096);
                for (int t = 2; t < NUM_TESTS; t++)
                    i_tab[t][r][k] = mm_pkg::elem_t'($urandom());
            end
        for (int c = 0; c < `MM_W_ROWS; c++)
            for (int k = 0; k < `MM_K; k++)
            begin
                w_tab[0][c][k] = mm_pkg::elem_t'((c + 1) * 128);       // 0.5 and 1.0
                w_tab[1][c][k] = (c == 0) ? mm_pkg::elem_t'(16'hFF00)  // Minus one
                                          : mm_pkg::elem_t'(16'h7F00 - k);
                for (int t = 2; t < NUM_TESTS; t++)
                    w_tab[t][c][k] = mm_pkg::elem_t'($urandom());
            end
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            for (int r = 0; r < `MM_I_ROWS; r++)
            begin
                i_rows.push_back(i_tab[t][r]);
                beat.data = ref_row(i_tab[t], w_tab[t], r);
                beat.last = (r == `MM_I_ROWS - 1);
                exp_q.push_back(beat);
                exp_test.push_back(t);
            end
            for (int c = 0; c < `MM_W_ROWS; c++)
                w_rows.push_back(w_tab[t][c]);
        end
    endtask

    // Both streams run without gaps, tready only holds a row
    task automatic drive_inputs();
        int n;
        n = 0;
        while (n < i_rows.size())
        begin
            @(negedge aclk);
            i_tvalid = 1'b1;
            i_tdata  = i_rows[n];
            if (i_tready)
                n++;                                  // Taken on the next rising edge
        end
        @(negedge aclk);
        i_tvalid = 1'b0;
    endtask

    task automatic drive_weights();
        int n;
        n = 0;
        while (n < w_rows.size())
        begin
            @(negedge aclk);
            w_tvalid = 1'b1;
            w_tdata  = w_rows[n];
            if (w_tready)
                n++;
        end
        @(negedge aclk);
        w_tvalid = 1'b0;
    endtask

    task automatic collect_beats();
        mm_pkg::out_beat_t got;
        logic              ready;
        while (exp_q.size() > 0)
        begin
            @(negedge aclk);
            ready    = stall_tab[exp_test[0]] ? 1'($urandom_range(0, 1)) : 1'b1;
            o_tready = ready;
            if (o_tvalid && ready)
            begin
                got.last = o_tlast;
                got.data = o_tdata;
                if (got !== exp_q[0])
                begin
                    errors++;
                    $display("Error: test %s expected %h actual %h",
                             test_name[exp_test[0]], exp_q[0], got);
                end
                checked++;
                void'(exp_q.pop_front());
                void'(exp_test.pop_front());
            end
        end
        @(negedge aclk);
        o_tready = 1'b0;                              // Leave any extra beat visible
    endtask

    initial
    begin : main
        i_tvalid = 1'b0;
        i_tdata  = '0;
        w_tvalid = 1'b0;
        w_tdata  = '0;
        o_tready = 1'b0;
        void'($urandom(33));
        build_table();
        wait (aresetn === 1'b1);
        @(negedge aclk);
        if (o_tvalid || !i_tready || !w_tready)
        begin
            errors++;
            $display("Stream handshake outputs wrong after reset");
        end
        fork
            drive_inputs();
            drive_weights();
            collect_beats();
        join
        repeat (8)
        begin
            @(negedge aclk);
            if (o_tvalid)
            begin
                errors++;
                $display("Output beat appeared after the last expected one");
            end
        end
        errors += mm_axis_tb.dut.chk.fail_count;
        $display("Summary: %0d errors, %0d beats checked", errors, checked);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* mm_axis_top.f */
+incdir+src
src/mm_pkg.sv
src/mm_if.sv
src/mm_stream_fifo.sv
src/mm_loader.sv
src/mm_compute.sv
src/mm_axis_top.sv
sim/tb_clk_gen.sv
sim/mm_axis_chk.sv
sim/mm_axis_tb.sv
